/* rtl/src_defs.svh */
// ======================================================================
// compile-time sizes of the source streamer
// port count, address and data widths, beat counter width
// ======================================================================

`ifndef SRC_DEFS_SVH
`define SRC_DEFS_SVH

`define SRC_NB_PORTS   4   // parallel memory ports, words per beat
`define SRC_ADDR_W     32  // byte address
`define SRC_WORD_W     32  // one memory word
`define SRC_CNT_W      16  // beat counter

// byte stride between neighbouring words
`define SRC_WORD_BYTES 4

`endif

/* rtl/src_pkg.sv */
// ======================================================================
// types shared by the source streamer
// address, word, wide beat, beat count and controller state
// ======================================================================

`include "src_defs.svh"

package src_pkg;

  // byte address into word-addressed memory
  typedef logic [`SRC_ADDR_W-1:0] addr_t;

  typedef logic [`SRC_WORD_W-1:0] word_t;  // single lane payload

  // one output beat, lane 0 sits in the low word
  typedef logic [`SRC_NB_PORTS-1:0][`SRC_WORD_W-1:0] beat_t;

  typedef logic [`SRC_CNT_W-1:0] cnt_t;    // beats per transfer

  // controller states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,  // waiting for start
    ST_WORKING = 2'd1,  // issuing beats
    ST_DRAIN   = 2'd2   // all issued, waiting on the stream
  } state_t;

endpackage

/* rtl/load_lane_if.sv */
// ======================================================================
// per-lane bundle between controller, memory lane and beat merge
// request level, fence status, advance pulse, held word and pop
// ======================================================================

interface load_lane_if;
  import src_pkg::*;

  // controller side
  logic  req;        // beat outstanding, level
  addr_t beat_addr;  // address of current beat, lane adds its offset
  logic  advance;    // one-cycle pulse, all lanes taken

  // lane side
  logic  taken;      // grant seen for current beat
  logic  valid;      // hold register full
  word_t word;       // held data

  logic  pop;        // merge side, beat accepted downstream

  modport ctrl (
    output req, beat_addr, advance,
    input  taken
  );

  modport lane (
    input  req, beat_addr, advance, pop,
    output taken, valid, word
  );

  modport merge (
    input  valid, word,
    output pop
  );

endinterface

/* rtl/src_addr_ctrl.sv */
// ======================================================================
// source streamer controller
// idle / working / drain FSM with start and done handshake
// beat address generator and issued / accepted beat counters
// ======================================================================

`include "src_defs.svh"

module src_addr_ctrl (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           clear_i,
  input  logic           start_i,
  input  src_pkg::addr_t base_addr_i,
  input  src_pkg::cnt_t  trans_size_i,
  input  logic           beat_done_i,
  output logic           ready_start_o,
  output logic           done_o,
  load_lane_if.ctrl      lanes [`SRC_NB_PORTS]
);
  import src_pkg::*;

  localparam addr_t BEAT_STEP = addr_t'(`SRC_NB_PORTS * `SRC_WORD_BYTES);

  state_t state_q, state_d;
  addr_t  addr_q;        // current beat address
  cnt_t   size_q;        // latched transfer length
  cnt_t   issue_cnt_q;   // beats fully granted
  cnt_t   accept_cnt_q;  // beats taken by the stream

  logic [`SRC_NB_PORTS-1:0] taken_vec;
  logic all_taken;
  logic advance;
  logic last_issue;
  logic last_accept;
  logic done_d;

  for (genvar g = 0; g < `SRC_NB_PORTS; g++) begin : g_lane_bind
    assign lanes[g].req       = (state_q == ST_WORKING);
    assign lanes[g].beat_addr = addr_q;
    assign lanes[g].advance   = advance;
    assign taken_vec[g]       = lanes[g].taken;
  end

  assign all_taken   = &taken_vec;
  assign advance     = (state_q == ST_WORKING) & all_taken;  // whole beat granted
  assign last_issue  = (issue_cnt_q == size_q - cnt_t'(1));
  assign last_accept = beat_done_i & (accept_cnt_q == size_q - cnt_t'(1));

  assign ready_start_o = (state_q == ST_IDLE);

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (start_i) state_d = ST_WORKING;
      end
      ST_WORKING: begin
        if (advance && last_issue) state_d = ST_DRAIN;  // nothing left to request
      end
      ST_DRAIN: begin
        if (last_accept) begin
          state_d = ST_IDLE;
          done_d  = 1'b1;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      done_o       <= 1'b0;
      issue_cnt_q  <= '0;
      accept_cnt_q <= '0;
    end else if (clear_i) begin
      state_q      <= ST_IDLE;
      done_o       <= 1'b0;
      issue_cnt_q  <= '0;
      accept_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      done_o  <= done_d;  // lands the cycle after the last handshake
      if (state_q == ST_IDLE) begin
        issue_cnt_q  <= '0;
        accept_cnt_q <= '0;
      end else begin
        if (advance)     issue_cnt_q  <= issue_cnt_q + cnt_t'(1);
        if (beat_done_i) accept_cnt_q <= accept_cnt_q + cnt_t'(1);
      end
    end
  end

  // transfer parameters and address walk
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && start_i) begin
      addr_q <= base_addr_i;
      size_q <= trans_size_i;
    end else if (advance) begin
      addr_q <= addr_q + BEAT_STEP;  // one beat forward
    end
  end

  // advance only while beats remain to be issued
  a_advance_working: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    advance |-> (issue_cnt_q < size_q));

endmodule

/* rtl/src_load_lane.sv */
// ======================================================================
// one memory read lane
// fenced request at beat address plus lane offset, grant tracking
// one-word hold register for the returned data
// ======================================================================

`include "src_defs.svh"

module src_load_lane #(
  parameter int unsigned LANE_IDX = 0
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           clear_i,
  output logic           mem_req_o,
  output src_pkg::addr_t mem_addr_o,
  input  logic           mem_gnt_i,
  input  logic           mem_r_valid_i,
  input  src_pkg::word_t mem_r_data_i,
  load_lane_if.lane      lane
);
  import src_pkg::*;

  localparam addr_t LANE_OFS = addr_t'(LANE_IDX * `SRC_WORD_BYTES);

  logic  taken_q;   // fence, granted for this beat
  logic  pend_q;    // read data due next cycle
  logic  valid_q;   // hold register full
  word_t word_q;
  logic  room;
  logic  granted;
  logic  load;

  assign room    = ~valid_q | lane.pop;  // hold frees up this cycle at the latest
  assign granted = mem_req_o & mem_gnt_i;
  assign load    = mem_r_valid_i & pend_q;  // stale returns after clear are dropped

  assign mem_req_o  = lane.req & ~taken_q & room;
  assign mem_addr_o = lane.beat_addr + LANE_OFS;

  assign lane.taken = taken_q;
  assign lane.valid = valid_q;
  assign lane.word  = word_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= 1'b0;
      pend_q  <= 1'b0;
      valid_q <= 1'b0;
    end else if (clear_i) begin
      taken_q <= 1'b0;
      pend_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      pend_q <= granted;
      if (lane.advance) taken_q <= 1'b0;  // siblings done, next beat
      else if (granted) taken_q <= 1'b1;
      if (load) valid_q <= 1'b1;
      else if (lane.pop) valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) word_q <= mem_r_data_i;
  end

  // memory answers only into a free or draining hold register
  a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_r_valid_i |-> (!valid_q || lane.pop));

endmodule

/* rtl/src_beat_merge.sv */
// ======================================================================
// beat merge
// joins the lane words into one wide beat, valid/ready handshake
// pops every lane and reports the accepted beat
// ======================================================================

`include "src_defs.svh"

module src_beat_merge (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           stream_ready_i,
  output logic           stream_valid_o,
  output src_pkg::beat_t stream_data_o,
  output logic           beat_done_o,
  load_lane_if.merge     lanes [`SRC_NB_PORTS]
);

  logic [`SRC_NB_PORTS-1:0] valid_vec;
  logic hs;

  for (genvar g = 0; g < `SRC_NB_PORTS; g++) begin : g_join
    assign valid_vec[g]     = lanes[g].valid;
    assign stream_data_o[g] = lanes[g].word;  // lane g in word g
    assign lanes[g].pop     = hs;
  end

  // beat complete only once every lane holds its word
  assign stream_valid_o = &valid_vec;
  assign hs             = stream_valid_o & stream_ready_i;
  assign beat_done_o    = hs;  // to the controller

  // stalled beat must not change under the consumer
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_valid_o && !stream_ready_i |=> $stable(stream_data_o));

endmodule

/* rtl/src_streamer.sv */
// ======================================================================
// source streamer top level
// controller, one read lane per memory port, beat merge
// ======================================================================

`include "src_defs.svh"

module src_streamer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  input  logic                                start_i,
  input  src_pkg::addr_t                      base_addr_i,
  input  src_pkg::cnt_t                       trans_size_i,
  output logic                                ready_start_o,
  output logic                                done_o,
  output logic           [`SRC_NB_PORTS-1:0] mem_req_o,
  output src_pkg::addr_t [`SRC_NB_PORTS-1:0] mem_addr_o,
  input  logic           [`SRC_NB_PORTS-1:0] mem_gnt_i,
  input  logic           [`SRC_NB_PORTS-1:0] mem_r_valid_i,
  input  src_pkg::word_t [`SRC_NB_PORTS-1:0] mem_r_data_i,
  input  logic                                stream_ready_i,
  output logic                                stream_valid_o,
  output src_pkg::beat_t                      stream_data_o
);

  logic beat_done;  // merge handshake to controller

  load_lane_if lane_if [`SRC_NB_PORTS] ();

  src_addr_ctrl i_ctrl (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( start_i       ),
    .base_addr_i   ( base_addr_i   ),
    .trans_size_i  ( trans_size_i  ),
    .beat_done_i   ( beat_done     ),
    .ready_start_o ( ready_start_o ),
    .done_o        ( done_o        ),
    .lanes         ( lane_if       )
  );

  for (genvar g = 0; g < `SRC_NB_PORTS; g++) begin : g_lane
    src_load_lane #(
      .LANE_IDX ( g )
    ) i_lane (
      .clk_i         ( clk_i            ),
      .rst_ni        ( rst_ni           ),
      .clear_i       ( clear_i          ),
      .mem_req_o     ( mem_req_o[g]     ),
      .mem_addr_o    ( mem_addr_o[g]    ),
      .mem_gnt_i     ( mem_gnt_i[g]     ),
      .mem_r_valid_i ( mem_r_valid_i[g] ),
      .mem_r_data_i  ( mem_r_data_i[g]  ),
      .lane          ( lane_if[g]       )
    );
  end

  src_beat_merge i_merge (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .stream_ready_i ( stream_ready_i ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  ),
    .beat_done_o    ( beat_done      ),
    .lanes          ( lane_if        )
  );

endmodule

/* test/tb_src_streamer.sv */
// ======================================================================
// testbench for the source streamer
// clock and reset, xorshift stimulus, random-grant memory model
// reference beat model, compare tasks, mid-transfer clear
// ======================================================================

`include "src_defs.svh"

module tb_src_streamer;
  timeunit 1ns;
  timeprecision 1ps;
  import src_pkg::*;

  localparam int NP      = `SRC_NB_PORTS;
  localparam int TIMEOUT = 5000;  // cycles allowed per wait

  logic           clk;
  logic           rst_n;
  logic           clear;
  logic           start;
  addr_t          base_addr;
  cnt_t           trans_size;
  logic           ready_start;
  logic           done;
  logic  [NP-1:0] mem_req;
  addr_t [NP-1:0] mem_addr;
  logic  [NP-1:0] mem_gnt;
  logic  [NP-1:0] mem_r_valid;
  word_t [NP-1:0] mem_r_data;
  logic           stream_ready;
  logic           stream_valid;
  beat_t          stream_data;

  logic [31:0]   rng_q;         // xorshift state
  logic          active;        // transfer under check
  int            beats_seen;    // accepted beats this transfer
  int            gnt_cnt [NP];  // grants per port this transfer
  logic          final_q;       // last beat accepted one cycle ago
  logic          stall_q;       // valid without ready one cycle ago
  beat_t         stall_data;
  logic [NP-1:0] gnt_q;         // grants answered next cycle
  addr_t         gnt_addr [NP];

  src_streamer dut (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear), .start_i (start),
    .base_addr_i (base_addr), .trans_size_i (trans_size),
    .ready_start_o (ready_start), .done_o (done),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_gnt_i (mem_gnt),
    .mem_r_valid_i (mem_r_valid), .mem_r_data_i (mem_r_data),
    .stream_ready_i (stream_ready), .stream_valid_o (stream_valid),
    .stream_data_o (stream_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_q = xorshift(rng_q);
    return rng_q;
  endfunction

  // memory word as a hash of the full byte address
  function automatic word_t mem_hash(addr_t a);
    return (a * 32'h9e37_79b1) ^ (a >> 11) ^ 32'h5a5a_0f0f;
  endfunction

  // byte address of word j in beat k
  function automatic addr_t word_addr(addr_t b, int k, int j);
    return b + addr_t'((k * NP + j) * `SRC_WORD_BYTES);
  endfunction

  function automatic beat_t model_beat(addr_t b, int k);
    beat_t r;
    int    j;
    for (j = 0; j < NP; j++)
      r[j] = mem_hash(word_addr(b, k, j));  // lane 0 in the low word
    return r;
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_beat(string name, beat_t got, beat_t exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  // per-cycle checks on the falling edge while a transfer runs
  task automatic check_cycle(logic hs);
    int j;
    check_flag("done_o", done, final_q);  // only right after the last beat
    check_flag("ready_start_o", ready_start, final_q);
    if (stall_q) begin
      check_flag("stream_valid_o", stream_valid, 1'b1);
      check_beat("stream_data_o", stream_data, stall_data);  // held while stalled
    end
    for (j = 0; j < NP; j++) begin
      if (gnt_q[j]) begin
        if (gnt_cnt[j] >= trans_size)
          stop_on_error($sformatf("port %0d granted past the end of the transfer", j));
        check_addr($sformatf("mem_addr_o[%0d]", j), mem_addr[j],
                   word_addr(base_addr, gnt_cnt[j], j));
        gnt_cnt[j]++;
      end
    end
    if (hs) begin
      if (beats_seen >= trans_size)
        stop_on_error("more output beats than trans_size_i");
      check_beat("stream_data_o", stream_data, model_beat(base_addr, beats_seen));
      beats_seen++;
    end
    if (final_q)
      active = 1'b0;  // transfer closed once done is seen
    final_q    = hs && (beats_seen == trans_size);
    stall_q    = stream_valid & ~stream_ready;
    stall_data = stream_data;
  endtask

  // memory with random grants and a random consumer
  initial begin : bus_model
    logic        hs;
    logic [31:0] r;
    int          j;
    forever begin
      @(negedge clk);
      hs    = stream_valid & stream_ready;
      gnt_q = mem_req & mem_gnt;
      for (j = 0; j < NP; j++)
        gnt_addr[j] = mem_addr[j];
      if (active)
        check_cycle(hs);
      @(posedge clk);
      #1;
      mem_r_valid = gnt_q;  // answer one cycle after the grant
      for (j = 0; j < NP; j++)
        mem_r_data[j] = gnt_q[j] ? mem_hash(gnt_addr[j]) : '0;
      r            = next_rand();
      mem_gnt      = r[NP-1:0];
      stream_ready = r[8] | r[9];  // ready about three cycles in four
    end
  end

  task automatic check_idle();
    @(negedge clk);
    check_flag("ready_start_o", ready_start, 1'b1);
    check_flag("done_o", done, 1'b0);
    check_flag("stream_valid_o", stream_valid, 1'b0);
    check_flag("mem_req_o", |mem_req, 1'b0);
  endtask

  task automatic start_transfer(int min_size, int span);
    logic [31:0] r;
    addr_t       b;
    int          j;
    @(negedge clk);
    b = next_rand() & ~addr_t'(3);  // word aligned
    r = next_rand() % span;
    @(posedge clk);
    #1;
    base_addr  = b;
    trans_size = cnt_t'(min_size + r);
    start      = 1'b1;
    beats_seen = 0;
    final_q    = 1'b0;
    stall_q    = 1'b0;
    for (j = 0; j < NP; j++)
      gnt_cnt[j] = 0;
    @(posedge clk);
    #1;
    start  = 1'b0;
    active = 1'b1;  // ready_start_o low from here on
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (active) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        stop_on_error("timeout while waiting for done_o");
    end
  endtask

  task automatic wait_beats(int target);
    int n;
    n = 0;
    while (beats_seen < target) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        stop_on_error("timeout while waiting for output beats");
    end
  endtask

  task automatic check_totals();
    int j;
    for (j = 0; j < NP; j++)
      if (gnt_cnt[j] != trans_size)
        stop_on_error($sformatf("port %0d saw the wrong number of grants", j));
  endtask

  task automatic full_transfer(int min_size, int span);
    start_transfer(min_size, span);
    wait_done();
    check_totals();
    check_idle();  // done_o back low after a single pulse
  endtask

  initial begin : main
    rng_q        = 32'd98;
    rst_n        = 1'b0;
    clear        = 1'b0;
    start        = 1'b0;
    base_addr    = '0;
    trans_size   = '0;
    mem_gnt      = '0;
    mem_r_valid  = '0;
    mem_r_data   = '0;
    stream_ready = 1'b0;
    active       = 1'b0;
    beats_seen   = 0;
    final_q      = 1'b0;
    stall_q      = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_idle();
    repeat (8)
      full_transfer(1, 16);
    // abort a long transfer halfway
    start_transfer(8, 12);
    wait_beats(2);
    @(posedge clk);
    #1;
    clear  = 1'b1;
    active = 1'b0;
    @(posedge clk);
    #1;
    clear = 1'b0;
    check_idle();  // reset state one cycle after clear
    full_transfer(1, 16);
    $display("Test passed");
    $finish;
  end

endmodule

/* src_streamer.f */
+incdir+rtl
rtl/src_pkg.sv
rtl/load_lane_if.sv
rtl/src_addr_ctrl.sv
rtl/src_load_lane.sv
rtl/src_beat_merge.sv
rtl/src_streamer.sv
test/tb_src_streamer.sv

/* Bender.yml */
package:
  name: src_streamer

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/src_pkg.sv
      - rtl/load_lane_if.sv
      - rtl/src_addr_ctrl.sv
      - rtl/src_load_lane.sv
      - rtl/src_beat_merge.sv
      - rtl/src_streamer.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_src_streamer.sv
